//--- logic/pong_pkg.sv
/*
 * pong_pkg: shared types for the pong display
 * screen coordinates, ball direction, raster and ball bundles
 */
package pong_pkg;

    localparam int cordw = 10;  // covers 800 columns, 525 lines

    // direction of travel on one axis
    typedef enum logic {
        dir_fwd  = 1'b0,  // right or down
        dir_back = 1'b1   // left or up
    } dir_t;

    // scan position plus everything derived from it
    // all fields valid in the same cycle
    typedef struct packed {
        logic [cordw-1:0] sx;     // column
        logic [cordw-1:0] sy;     // line
        logic             de;     // in active area
        logic             hsync;  // low active
        logic             vsync;  // low active
        logic             frame;  // one cycle at first blanking line
    } raster_t;

    // ball box corner and travel direction
    typedef struct packed {
        logic [cordw-1:0] bx;  // left edge
        logic [cordw-1:0] by;  // top edge
        dir_t             dx;  // horizontal direction
        dir_t             dy;  // vertical direction
    } ball_t;

endpackage

//--- logic/display_timings.sv
/*
 * display_timings: VGA raster generator
 * scan counters, negative syncs, data enable and frame strobe
 */
module display_timings #(
    parameter int h_res  = 640,  // active columns
    parameter int h_fp   = 16,   // horizontal front porch
    parameter int h_sync = 96,   // hsync width
    parameter int h_bp   = 48,   // horizontal back porch
    parameter int v_res  = 480,  // active lines
    parameter int v_fp   = 10,   // vertical front porch
    parameter int v_sync = 2,    // vsync width
    parameter int v_bp   = 33    // vertical back porch
) (
    input  logic              clk_pix,
    input  logic              rst,
    output pong_pkg::raster_t raster
);

    import pong_pkg::*;

    // line and frame totals
    localparam int h_total = h_res + h_fp + h_sync + h_bp;
    localparam int v_total = v_res + v_fp + v_sync + v_bp;

    // comparison points, sized to the counters
    localparam logic [cordw-1:0] h_last   = cordw'(h_total - 1);  // last column
    localparam logic [cordw-1:0] v_last   = cordw'(v_total - 1);  // last line
    localparam logic [cordw-1:0] h_act    = cordw'(h_res);
    localparam logic [cordw-1:0] v_act    = cordw'(v_res);
    localparam logic [cordw-1:0] hs_start = cordw'(h_res + h_fp);
    localparam logic [cordw-1:0] hs_end   = cordw'(h_res + h_fp + h_sync);
    localparam logic [cordw-1:0] vs_start = cordw'(v_res + v_fp);
    localparam logic [cordw-1:0] vs_end   = cordw'(v_res + v_fp + v_sync);

    logic [cordw-1:0] sx;  // current column
    logic [cordw-1:0] sy;  // current line

    // scan counters, one pixel per clock
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == h_last) begin  // end of line
            sx <= '0;
            if (sy == v_last) begin  // end of frame
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // everything else follows the counters in the same cycle
    always_comb begin
        raster.sx    = sx;
        raster.sy    = sy;
        raster.de    = (sx < h_act) && (sy < v_act);
        raster.hsync = ~((sx >= hs_start) && (sx < hs_end));  // low in pulse
        raster.vsync = ~((sy >= vs_start) && (sy < vs_end));
        // first pixel of the first blanking line
        raster.frame = (sy == v_act) && (sx == '0);
    end

endmodule

//--- logic/ball_motion.sv
/*
 * ball_motion: moves the ball once per frame
 * fixed step per axis, reverses at the screen edges
 */
module ball_motion #(
    parameter int h_res   = 640,  // active width
    parameter int v_res   = 480,  // active height
    parameter int b_size  = 8,    // ball side in pixels
    parameter int speed_x = 1,    // step per frame, horizontal
    parameter int speed_y = 1     // step per frame, vertical
) (
    input  logic            clk_pix,
    input  logic            rst,
    input  logic            frame,
    output pong_pkg::ball_t ball
);

    import pong_pkg::*;

    // one axis of the ball state
    typedef struct packed {
        dir_t             d;  // travel direction
        logic [cordw-1:0] p;  // corner position
    } axis_t;

    // steps and bounce limits, sized to coordinates
    localparam logic [cordw-1:0] step_x = cordw'(speed_x);
    localparam logic [cordw-1:0] step_y = cordw'(speed_y);
    localparam logic [cordw-1:0] lim_x  = cordw'(h_res - (speed_x + b_size));  // right edge
    localparam logic [cordw-1:0] lim_y  = cordw'(v_res - (speed_y + b_size));  // bottom edge

    axis_t ax;      // horizontal state
    axis_t ay;      // vertical state
    axis_t ax_nxt;
    axis_t ay_nxt;

    // bounce rule for a single axis
    function automatic axis_t bounce(
        input axis_t            cur,
        input logic [cordw-1:0] spd,
        input logic [cordw-1:0] lim
    );
        axis_t nxt;
        nxt = cur;
        if (cur.p >= lim) begin  // far edge, turn back
            nxt.d = dir_back;
            nxt.p = cur.p - spd;
        end else if (cur.p < spd) begin  // near edge, turn forward
            nxt.d = dir_fwd;
            nxt.p = cur.p + spd;
        end else if (cur.d == dir_back) begin
            nxt.p = cur.p - spd;
        end else begin
            nxt.p = cur.p + spd;
        end
        return nxt;
    endfunction

    // candidate positions for the next strobe
    always_comb begin
        ax_nxt = bounce(ax, step_x, lim_x);
        ay_nxt = bounce(ay, step_y, lim_y);
    end

    // update only at the frame strobe, constant otherwise
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            ax <= '{d: dir_fwd, p: '0};  // origin, heading right
            ay <= '{d: dir_fwd, p: '0};  // heading down
        end else if (frame) begin
            ax <= ax_nxt;
            ay <= ay_nxt;
        end
    end

    // pack for the renderer
    always_comb begin
        ball.bx = ax.p;
        ball.by = ay.p;
        ball.dx = ax.d;
        ball.dy = ay.d;
    end

endmodule

//--- logic/pong_render.sv
/*
 * pong_render: draws the ball and registers the VGA outputs
 * syncs travel with the colour so all outputs lag one cycle
 */
module pong_render #(
    parameter int b_size = 8  // ball side in pixels
) (
    input  logic              clk_pix,
    input  logic              rst,
    input  pong_pkg::raster_t raster,
    input  pong_pkg::ball_t   ball,
    output logic              vga_hsync,
    output logic              vga_vsync,
    output logic [3:0]        vga_r,
    output logic [3:0]        vga_g,
    output logic [3:0]        vga_b
);

    import pong_pkg::*;

    logic [cordw-1:0] bx_end;  // first column past the ball
    logic [cordw-1:0] by_end;  // first line past the ball
    logic             hit;     // scan position inside ball box
    logic [3:0]       pix;     // grey level for this pixel

    always_comb begin
        bx_end = ball.bx + cordw'(b_size);
        by_end = ball.by + cordw'(b_size);
        hit = (raster.sx >= ball.bx) && (raster.sx < bx_end)
           && (raster.sy >= ball.by) && (raster.sy < by_end);
        pix = (hit && raster.de) ? 4'hF : 4'h0;  // black in blanking
    end

    // output stage, one cycle behind the raster
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vga_hsync <= 1'b1;  // inactive
            vga_vsync <= 1'b1;
            vga_r     <= 4'h0;
            vga_g     <= 4'h0;
            vga_b     <= 4'h0;
        end else begin
            vga_hsync <= raster.hsync;
            vga_vsync <= raster.vsync;
            vga_r     <= pix;  // white ball, same on all channels
            vga_g     <= pix;
            vga_b     <= pix;
        end
    end

endmodule

//--- logic/pong_top.sv
/*
 * pong_top: single ball pong on a VGA raster
 * timing, ball motion and renderer on the pixel clock
 */
module pong_top #(
    parameter int h_res   = 640,  // active columns
    parameter int h_fp    = 16,
    parameter int h_sync  = 96,
    parameter int h_bp    = 48,
    parameter int v_res   = 480,  // active lines
    parameter int v_fp    = 10,
    parameter int v_sync  = 2,
    parameter int v_bp    = 33,
    parameter int b_size  = 8,    // ball side
    parameter int speed_x = 1,    // pixels per frame
    parameter int speed_y = 1
) (
    input  logic       clk_pix,
    input  logic       rst,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    import pong_pkg::*;

    raster_t raster;  // scan position and syncs
    ball_t   ball;    // ball box, stable within a frame

    display_timings #(
        .h_res (h_res),
        .h_fp  (h_fp),
        .h_sync(h_sync),
        .h_bp  (h_bp),
        .v_res (v_res),
        .v_fp  (v_fp),
        .v_sync(v_sync),
        .v_bp  (v_bp)
    ) u_timings (
        .clk_pix(clk_pix),
        .rst    (rst),
        .raster (raster)
    );

    // moves on the frame strobe only
    ball_motion #(
        .h_res  (h_res),
        .v_res  (v_res),
        .b_size (b_size),
        .speed_x(speed_x),
        .speed_y(speed_y)
    ) u_ball (
        .clk_pix(clk_pix),
        .rst    (rst),
        .frame  (raster.frame),
        .ball   (ball)
    );

    pong_render #(
        .b_size(b_size)
    ) u_render (
        .clk_pix  (clk_pix),
        .rst      (rst),
        .raster   (raster),
        .ball     (ball),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_r    (vga_r),
        .vga_g    (vga_g),
        .vga_b    (vga_b)
    );

endmodule

//--- dv/pong_asserts.sv
/*
 * pong_asserts: concurrent checks bound into pong_top
 * frame strobe, ball limits, blanking and hsync width
 */
module pong_asserts #(
    parameter int h_res  = 640,
    parameter int v_res  = 480,
    parameter int b_size = 8,
    parameter int h_sync = 96
) (
    input logic              clk_pix,
    input logic              rst,
    input pong_pkg::raster_t raster,
    input pong_pkg::ball_t   ball,
    input logic              vga_hsync,
    input logic [3:0]        vga_r,
    input logic [3:0]        vga_g,
    input logic [3:0]        vga_b
);

    import pong_pkg::*;

    localparam logic [cordw-1:0] bx_max = cordw'(h_res - b_size);  // rightmost corner
    localparam logic [cordw-1:0] by_max = cordw'(v_res - b_size);  // lowest corner

    int low_cnt;  // length of current hsync low run

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            low_cnt <= 0;  // cut pulses do not count
        end else if (!vga_hsync) begin
            low_cnt <= low_cnt + 1;
        end else begin
            low_cnt <= 0;
        end
    end

    frame_single: assert property (@(posedge clk_pix) disable iff (rst)
        raster.frame |=> !raster.frame)
        else $error("frame strobe high for two cycles");

    ball_inside: assert property (@(posedge clk_pix) disable iff (rst)
        (ball.bx <= bx_max) && (ball.by <= by_max))
        else $error("ball outside active area");

    blank_dark: assert property (@(posedge clk_pix) disable iff (rst)
        !raster.de |=> (vga_r == 4'h0) && (vga_g == 4'h0) && (vga_b == 4'h0))
        else $error("colour not black after blanking pixel");

    hsync_width: assert property (@(posedge clk_pix) disable iff (rst)
        ($rose(vga_hsync) && (low_cnt != 0)) |-> (low_cnt == h_sync))
        else $error("hsync pulse width wrong");

endmodule

bind pong_top pong_asserts #(
    .h_res (h_res),
    .v_res (v_res),
    .b_size(b_size),
    .h_sync(h_sync)
) u_asserts (
    .clk_pix  (clk_pix),
    .rst      (rst),
    .raster   (raster),
    .ball     (ball),
    .vga_hsync(vga_hsync),
    .vga_r    (vga_r),
    .vga_g    (vga_g),
    .vga_b    (vga_b)
);

//--- dv/pong_tb.sv
/*
 * pong_tb: random reset testbench for pong_top on a small screen
 * reference raster and ball model, every output checked every pixel
 */
module pong_tb;

    localparam int h_res   = 40;  // reduced screen for many frames
    localparam int h_fp    = 4;
    localparam int h_sync  = 6;
    localparam int h_bp    = 6;
    localparam int v_res   = 24;
    localparam int v_fp    = 2;
    localparam int v_sync  = 2;
    localparam int v_bp    = 3;
    localparam int b_size  = 4;
    localparam int speed_x = 3;
    localparam int speed_y = 2;

    localparam int h_total    = h_res + h_fp + h_sync + h_bp;
    localparam int v_total    = v_res + v_fp + v_sync + v_bp;
    localparam int frame_len  = h_total * v_total;
    localparam int n_frames   = 60;
    localparam int wait_limit = 3 * frame_len;  // one frame plus a restart after reset

    logic       clk_pix;
    logic       rst;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;

    int         m_sx;        // model column
    int         m_sy;        // model line
    int         m_bx;        // model ball corner
    int         m_by;
    bit         m_x_back;    // model direction, set means left
    bit         m_y_back;    // set means up
    bit         rst_prev;    // rst as seen by the last rising edge
    logic       exp_hs;      // expected outputs, already one cycle late
    logic       exp_vs;
    logic [3:0] exp_col;
    bit         exp_de_d;    // de that goes with exp_col
    int         errors;
    int         seed;
    int         frames_run;
    bit         timed_out;

    pong_top #(
        .h_res  (h_res),
        .h_fp   (h_fp),
        .h_sync (h_sync),
        .h_bp   (h_bp),
        .v_res  (v_res),
        .v_fp   (v_fp),
        .v_sync (v_sync),
        .v_bp   (v_bp),
        .b_size (b_size),
        .speed_x(speed_x),
        .speed_y(speed_y)
    ) uut (
        .clk_pix  (clk_pix),
        .rst      (rst),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_r    (vga_r),
        .vga_g    (vga_g),
        .vga_b    (vga_b)
    );

    always #5 clk_pix = ~clk_pix;  // period 10

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
        end
    endtask

    // edge bounce, same rule on both axes
    task automatic bounce_axis(inout int pos, inout bit back, input int res, input int spd);
        if (pos >= res - (spd + b_size)) begin  // far edge
            back = 1'b1;
            pos  = pos - spd;
        end else if (pos < spd) begin  // near edge
            back = 1'b0;
            pos  = pos + spd;
        end else if (back) begin
            pos = pos - spd;
        end else begin
            pos = pos + spd;
        end
    endtask

    // what the last rising edge did to the DUT
    task automatic model_edge();
        bit de;
        bit hit;
        if (rst_prev) begin
            m_sx     = 0;
            m_sy     = 0;
            m_bx     = 0;  // origin, heading right and down
            m_by     = 0;
            m_x_back = 1'b0;
            m_y_back = 1'b0;
            exp_hs   = 1'b1;  // syncs idle
            exp_vs   = 1'b1;
            exp_col  = 4'h0;
            exp_de_d = 1'b0;
        end else begin
            de  = (m_sx < h_res) && (m_sy < v_res);
            hit = (m_sx >= m_bx) && (m_sx < m_bx + b_size)
               && (m_sy >= m_by) && (m_sy < m_by + b_size);
            exp_hs   = !((m_sx >= h_res + h_fp) && (m_sx < h_res + h_fp + h_sync));
            exp_vs   = !((m_sy >= v_res + v_fp) && (m_sy < v_res + v_fp + v_sync));
            exp_col  = (hit && de) ? 4'hF : 4'h0;  // old ball still drawn at the strobe
            exp_de_d = de;
            if (m_sy == v_res && m_sx == 0) begin  // frame strobe
                bounce_axis(m_bx, m_x_back, h_res, speed_x);
                bounce_axis(m_by, m_y_back, v_res, speed_y);
            end
            if (m_sx == h_total - 1) begin  // line wrap
                m_sx = 0;
                m_sy = (m_sy == v_total - 1) ? 0 : m_sy + 1;
            end else begin
                m_sx++;
            end
        end
    endtask

    task automatic compare_outputs(input bit was_rst);
        check("hsync", 32'(exp_hs), 32'(vga_hsync));
        check("vsync", 32'(exp_vs), 32'(vga_vsync));
        check("pixel_r", 32'(exp_col), 32'(vga_r));
        check("pixel_g", 32'(exp_col), 32'(vga_g));
        check("pixel_b", 32'(exp_col), 32'(vga_b));
        if (!exp_de_d) begin  // blanking, all channels dark
            check("blank", 32'h0, 32'({vga_r, vga_g, vga_b}));
        end
        if (was_rst) begin  // outputs idle right after reset
            check("rst_hsync", 32'h1, 32'(vga_hsync));
            check("rst_vsync", 32'h1, 32'(vga_vsync));
            check("rst_colour", 32'h0, 32'({vga_r, vga_g, vga_b}));
        end
    endtask

    // one pixel clock, checked and driven at the falling edge
    task automatic step_cycle(input bit rst_next);
        bit was_rst;
        @(negedge clk_pix);
        was_rst = rst_prev;
        model_edge();
        compare_outputs(was_rst);
        rst      = rst_next;  // taken at the next rising edge
        rst_prev = rst_next;
    endtask

    // runs until the DUT starts its next vsync pulse
    task automatic run_frame();
        int   cyc;
        int   rst_at;
        int   rst_len;
        bit   do_rst;
        bit   seen;
        logic vs_last;
        do_rst  = ({$random(seed)} % 8) == 0;  // 1 in 8 frames
        rst_at  = {$random(seed)} % frame_len;
        rst_len = 1 + {$random(seed)} % 3;
        cyc     = 0;
        seen    = 1'b0;
        vs_last = vga_vsync;
        while (!seen && cyc < wait_limit) begin
            step_cycle(do_rst && (cyc >= rst_at) && (cyc < rst_at + rst_len));
            if (vs_last === 1'b1 && vga_vsync === 1'b0) begin
                seen = 1'b1;
            end
            vs_last = vga_vsync;
            cyc++;
        end
        if (!seen) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR: no vsync pulse from the DUT within %0d cycles", wait_limit);
        end
    endtask

    initial begin
        clk_pix    = 1'b0;
        rst        = 1'b1;  // first rising edge already in reset
        rst_prev   = 1'b1;
        seed       = 32'h8410;
        errors     = 0;
        frames_run = 0;
        timed_out  = 1'b0;
        m_sx       = 0;
        m_sy       = 0;
        m_bx       = 0;
        m_by       = 0;
        m_x_back   = 1'b0;
        m_y_back   = 1'b0;
        repeat (3) step_cycle(1'b1);  // 4 rising edges in reset
        while (frames_run < n_frames && !timed_out) begin
            run_frame();
            frames_run++;
        end
        $display("done: %0d frames, %0d errors", frames_run, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- files.f
logic/pong_pkg.sv
logic/display_timings.sv
logic/ball_motion.sv
logic/pong_render.sv
logic/pong_top.sv
dv/pong_asserts.sv
dv/pong_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pong testbench with Verilator
# the result comes from the simulation log

set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pong_tb -f files.f -o pong_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/pong_sim > "$log" 2>&1 \
    || echo "simulator returned an error status"

grep -q "^sim passed$" "$log" \
    && { echo "simulation passed, log in $log"; exit 0; } \
    || { echo "simulation failed, log in $log"; exit 1; }
